// File: hw/ramio_pkg.sv
// ======================================================================
// ramio shared definitions
// address map, data widths, access type codes and UART bit timing
// ======================================================================
`default_nettype none

package ramio_pkg;

  // byte address and data word of the client bus
  typedef logic [31:0] addr_t;
  typedef logic [31:0] word_t;

  // bit n enables byte lane n
  typedef logic [3:0] byte_en_t;

  // word index into the local RAM, address bits 9:2
  typedef logic [7:0] ram_index_t;

  // 000 no read, [1:0] size (01 byte, 10 half, 11 word), [2] sign extend
  typedef logic [2:0] read_type_t;

  // 00 no write, 01 byte, 10 half word, 11 word
  typedef logic [1:0] write_type_t;

  // one UART character
  typedef logic [7:0] uart_byte_t;

  // memory-mapped I/O
  localparam addr_t ADDR_LED      = 32'hffff_fffc;
  localparam addr_t ADDR_UART_OUT = 32'hffff_fff8;
  localparam addr_t ADDR_UART_IN  = 32'hffff_fff4;

  // idle tx mailbox or empty rx mailbox
  localparam word_t MAILBOX_EMPTY = 32'hffff_ffff;

  localparam int RAM_WORDS = 256;

  // clocks per UART bit, kept short for simulation
  localparam int CLKS_PER_BIT = 8;
  localparam int BIT_TIME_W   = $clog2(CLKS_PER_BIT) + 1;
  typedef logic [BIT_TIME_W-1:0] bit_time_t;

  typedef enum logic [2:0] {
    TX_IDLE,
    TX_START,
    TX_DATA,
    TX_STOP,
    TX_DONE
  } uart_tx_state_t;

  typedef enum logic [2:0] {
    RX_IDLE,
    RX_START,
    RX_DATA,
    RX_STOP,
    RX_DONE
  } uart_rx_state_t;

endpackage

`default_nettype wire

// File: hw/word_ram.sv
// ======================================================================
// word_ram: local word-wide RAM
// byte-masked writes, registered read one cycle after the index
// ======================================================================
`timescale 1ns/1ps
`default_nettype none

module word_ram (
  input  wire                    clk,
  input  wire                    rst_n,
  input  wire                    ram_en,
  input  ramio_pkg::ram_index_t  ram_index,
  input  ramio_pkg::byte_en_t    ram_byte_en,
  input  ramio_pkg::word_t       ram_wdata,
  output ramio_pkg::word_t       ram_rdata,
  output logic                   ram_ready
);

  ramio_pkg::word_t mem [ramio_pkg::RAM_WORDS];

  // write enabled lanes, read every cycle
  always_ff @(posedge clk) begin
    if (ram_en) begin
      for (int i = 0; i < $bits(ramio_pkg::byte_en_t); i++) begin
        if (ram_byte_en[i]) begin
          mem[ram_index][8*i +: 8] <= ram_wdata[8*i +: 8];
        end
      end
    end
    ram_rdata <= mem[ram_index];
  end

  // read data valid from the second cycle of a held read
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ram_ready <= 1'b0;
    end else begin
      ram_ready <= ram_en && (ram_byte_en == '0);
    end
  end

endmodule

`default_nettype wire

// File: hw/io_regs.sv
// ======================================================================
// io_regs: LED register and UART mailboxes
// runs the go/acknowledge levels towards the UART transmitter and
// receiver and returns the addressed register on reads
// ======================================================================
`timescale 1ns/1ps
`default_nettype none

module io_regs (
  input  wire                    clk,
  input  wire                    rst_n,
  input  wire                    io_sel_led,
  input  wire                    io_sel_out,
  input  wire                    io_sel_in,
  input  wire                    io_wr,
  input  wire                    io_rd,
  input  ramio_pkg::word_t       io_wdata,
  output logic [3:0]             led,
  output ramio_pkg::word_t       io_rdata,
  output logic                   tx_go,
  output ramio_pkg::uart_byte_t  tx_data,
  input  wire                    tx_busy,
  output logic                   rx_go,
  input  ramio_pkg::uart_byte_t  rx_data,
  input  wire                    rx_data_ready
);

  ramio_pkg::word_t tx_mailbox;
  ramio_pkg::word_t rx_mailbox;

  // set in the cycle after raising tx_go, busy is not up yet
  logic tx_guard;

  // active low LEDs, all off out of reset
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      led <= 4'b1111;
    end else if (io_sel_led && io_wr) begin
      led <= io_wdata[3:0];
    end
  end

  // transmit mailbox
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      tx_mailbox <= ramio_pkg::MAILBOX_EMPTY;
      tx_go      <= 1'b0;
      tx_guard   <= 1'b0;
    end else begin
      tx_guard <= 1'b0;
      // frame finished, acknowledge and go idle
      if (tx_go && !tx_busy && !tx_guard) begin
        tx_go      <= 1'b0;
        tx_mailbox <= ramio_pkg::MAILBOX_EMPTY;
      end
      // a new write wins over the acknowledge
      if (io_sel_out && io_wr) begin
        tx_mailbox <= {24'h0, io_wdata[7:0]};
        tx_go      <= 1'b1;
        tx_guard   <= 1'b1;
      end
    end
  end

  assign tx_data = tx_mailbox[7:0];

  // receive mailbox
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rx_mailbox <= ramio_pkg::MAILBOX_EMPTY;
      rx_go      <= 1'b1;
    end else begin
      // one low cycle acknowledges, then listen again
      if (!rx_go) begin
        rx_go <= 1'b1;
      end
      // capture first so a polling read cannot starve it
      // an unread byte is simply overwritten
      if (rx_go && rx_data_ready) begin
        rx_mailbox <= {24'h0, rx_data};
        rx_go      <= 1'b0;
      end else if (io_sel_in && io_rd) begin
        rx_mailbox <= ramio_pkg::MAILBOX_EMPTY;
      end
    end
  end

  // read mux
  always_comb begin
    io_rdata = '0;
    if (io_sel_led) begin
      io_rdata = {28'h0, led};
    end else if (io_sel_out) begin
      io_rdata = tx_mailbox;
    end else if (io_sel_in) begin
      io_rdata = rx_mailbox;
    end
  end

endmodule

`default_nettype wire

// File: hw/uart_tx.sv
// ======================================================================
// uart_tx: serial transmitter, 8 data bits, no parity, 1 stop bit
// starts on go, drops busy after the stop bit, idles once go falls
// ======================================================================
`timescale 1ns/1ps
`default_nettype none

module uart_tx (
  input  wire                    clk,
  input  wire                    rst_n,
  input  wire                    go,
  input  ramio_pkg::uart_byte_t  data,
  output logic                   tx,
  output logic                   busy
);

  localparam ramio_pkg::bit_time_t LAST_CLK =
    ramio_pkg::bit_time_t'(ramio_pkg::CLKS_PER_BIT - 1);

  ramio_pkg::uart_tx_state_t state;
  ramio_pkg::bit_time_t      clk_cnt;
  logic [2:0]                bit_idx;
  ramio_pkg::uart_byte_t     shift;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state   <= ramio_pkg::TX_IDLE;
      tx      <= 1'b1;
      busy    <= 1'b0;
      clk_cnt <= '0;
      bit_idx <= '0;
    end else begin
      case (state)
        ramio_pkg::TX_IDLE: begin
          tx <= 1'b1;
          if (go) begin
            // latch the byte and drive the start bit
            shift   <= data;
            busy    <= 1'b1;
            clk_cnt <= '0;
            tx      <= 1'b0;
            state   <= ramio_pkg::TX_START;
          end
        end
        ramio_pkg::TX_START: begin
          if (clk_cnt == LAST_CLK) begin
            clk_cnt <= '0;
            bit_idx <= '0;
            tx      <= shift[0];
            state   <= ramio_pkg::TX_DATA;
          end else begin
            clk_cnt <= clk_cnt + 1'b1;
          end
        end
        ramio_pkg::TX_DATA: begin
          if (clk_cnt == LAST_CLK) begin
            clk_cnt <= '0;
            if (bit_idx == 3'd7) begin
              tx    <= 1'b1;
              state <= ramio_pkg::TX_STOP;
            end else begin
              // lsb first
              bit_idx <= bit_idx + 1'b1;
              shift   <= shift >> 1;
              tx      <= shift[1];
            end
          end else begin
            clk_cnt <= clk_cnt + 1'b1;
          end
        end
        ramio_pkg::TX_STOP: begin
          if (clk_cnt == LAST_CLK) begin
            busy  <= 1'b0;
            state <= ramio_pkg::TX_DONE;
          end else begin
            clk_cnt <= clk_cnt + 1'b1;
          end
        end
        ramio_pkg::TX_DONE: begin
          // hold until the owner acknowledges
          if (!go) begin
            state <= ramio_pkg::TX_IDLE;
          end
        end
        default: state <= ramio_pkg::TX_IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: hw/uart_rx.sv
// ======================================================================
// uart_rx: serial receiver, 8 data bits, no parity, 1 stop bit
// samples mid-bit, holds data_ready until go falls
// ======================================================================
`timescale 1ns/1ps
`default_nettype none

module uart_rx (
  input  wire                    clk,
  input  wire                    rst_n,
  input  wire                    rx,
  input  wire                    go,
  output ramio_pkg::uart_byte_t  data,
  output logic                   data_ready
);

  localparam ramio_pkg::bit_time_t LAST_CLK =
    ramio_pkg::bit_time_t'(ramio_pkg::CLKS_PER_BIT - 1);
  localparam ramio_pkg::bit_time_t HALF_CLK =
    ramio_pkg::bit_time_t'(ramio_pkg::CLKS_PER_BIT / 2 - 1);

  ramio_pkg::uart_rx_state_t state;
  ramio_pkg::bit_time_t      clk_cnt;
  logic [2:0]                bit_idx;

  // two-flop synchroniser plus one more for edge detect
  logic rx_meta;
  logic rx_sync;
  logic rx_prev;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
      rx_prev <= 1'b1;
    end else begin
      rx_meta <= rx;
      rx_sync <= rx_meta;
      rx_prev <= rx_sync;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state      <= ramio_pkg::RX_IDLE;
      data_ready <= 1'b0;
      clk_cnt    <= '0;
      bit_idx    <= '0;
    end else begin
      case (state)
        ramio_pkg::RX_IDLE: begin
          // falling edge starts a frame
          if (go && rx_prev && !rx_sync) begin
            clk_cnt <= '0;
            state   <= ramio_pkg::RX_START;
          end
        end
        ramio_pkg::RX_START: begin
          if (clk_cnt == HALF_CLK) begin
            clk_cnt <= '0;
            bit_idx <= '0;
            // glitch, not a real start bit
            state   <= rx_sync ? ramio_pkg::RX_IDLE : ramio_pkg::RX_DATA;
          end else begin
            clk_cnt <= clk_cnt + 1'b1;
          end
        end
        ramio_pkg::RX_DATA: begin
          if (clk_cnt == LAST_CLK) begin
            clk_cnt <= '0;
            data    <= {rx_sync, data[7:1]};
            bit_idx <= bit_idx + 1'b1;
            if (bit_idx == 3'd7) begin
              state <= ramio_pkg::RX_STOP;
            end
          end else begin
            clk_cnt <= clk_cnt + 1'b1;
          end
        end
        ramio_pkg::RX_STOP: begin
          if (clk_cnt == LAST_CLK) begin
            // bad stop bit drops the frame
            if (rx_sync) begin
              data_ready <= 1'b1;
              state      <= ramio_pkg::RX_DONE;
            end else begin
              state <= ramio_pkg::RX_IDLE;
            end
          end else begin
            clk_cnt <= clk_cnt + 1'b1;
          end
        end
        ramio_pkg::RX_DONE: begin
          if (!go) begin
            data_ready <= 1'b0;
            state      <= ramio_pkg::RX_IDLE;
          end
        end
        default: state <= ramio_pkg::RX_IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: hw/ramio.sv
// ======================================================================
// ramio: memory-mapped access unit
// decodes client requests to the local RAM or the I/O registers,
// steers write lanes and extends read data by access type
// ======================================================================
`timescale 1ns/1ps
`default_nettype none

module ramio (
  input  wire                      clk,
  input  wire                      rst_n,
  input  wire                      enable,
  input  ramio_pkg::read_type_t    read_type,
  input  ramio_pkg::write_type_t   write_type,
  input  ramio_pkg::addr_t         address,
  input  ramio_pkg::word_t         data_in,
  output ramio_pkg::word_t         data_out,
  output logic                     data_out_ready,
  output logic [3:0]               led,
  output logic                     uart_tx,
  input  wire                      uart_rx
);

  // RAM side
  logic                  ram_en;
  ramio_pkg::ram_index_t ram_index;
  ramio_pkg::byte_en_t   ram_byte_en;
  ramio_pkg::word_t      ram_wdata;
  ramio_pkg::word_t      ram_rdata;
  logic                  ram_ready;

  // I/O side
  logic                  io_sel_led;
  logic                  io_sel_out;
  logic                  io_sel_in;
  logic                  io_hit;
  logic                  io_wr;
  logic                  io_rd;
  ramio_pkg::word_t      io_rdata;

  // UART handshakes
  logic                  tx_go;
  ramio_pkg::uart_byte_t tx_data;
  logic                  tx_busy;
  logic                  rx_go;
  ramio_pkg::uart_byte_t rx_data;
  logic                  rx_data_ready;

  // lanes picked out of the RAM word for narrow reads
  logic [7:0]            rd_byte;
  logic [15:0]           rd_half;

  // address decode, anything not I/O goes to RAM
  assign io_sel_led = (address == ramio_pkg::ADDR_LED);
  assign io_sel_out = (address == ramio_pkg::ADDR_UART_OUT);
  assign io_sel_in  = (address == ramio_pkg::ADDR_UART_IN);
  assign io_hit     = io_sel_led | io_sel_out | io_sel_in;

  assign io_wr  = enable && (write_type != '0);
  assign io_rd  = enable && (read_type != '0);
  assign ram_en = enable && !io_hit;

  // word index only, so the RAM repeats every 1 KB
  assign ram_index = address[9:2];

  // I/O answers at once, RAM after its registered read
  assign data_out_ready = io_hit ? 1'b1 : ram_ready;

  // write lane steering into a byte-enabled word write
  always_comb begin
    ram_byte_en = '0;
    ram_wdata   = '0;
    if (ram_en) begin
      case (write_type)
        2'b01: begin
          // byte replicated on all lanes, only one enabled
          ram_wdata   = {4{data_in[7:0]}};
          ram_byte_en = 4'b0001 << address[1:0];
        end
        2'b10: begin
          ram_wdata = {2{data_in[15:0]}};
          // odd offsets write nothing
          case (address[1:0])
            2'b00:   ram_byte_en = 4'b0011;
            2'b10:   ram_byte_en = 4'b1100;
            default: ram_byte_en = 4'b0000;
          endcase
        end
        2'b11: begin
          ram_wdata   = data_in;
          ram_byte_en = 4'b1111;
        end
        default: ;
      endcase
    end
  end

  // addressed lanes of the word just read
  assign rd_byte = ram_rdata[{address[1:0], 3'b000} +: 8];
  assign rd_half = address[1] ? ram_rdata[31:16] : ram_rdata[15:0];

  always_comb begin
    data_out = '0;
    if (io_rd) begin
      if (io_hit) begin
        // mailboxes and LED come back untouched
        data_out = io_rdata;
      end else begin
        case (read_type[1:0])
          2'b01: data_out = {{24{read_type[2] & rd_byte[7]}}, rd_byte};
          2'b10: begin
            // misaligned half word reads as zero
            if (!address[0]) begin
              data_out = {{16{read_type[2] & rd_half[15]}}, rd_half};
            end
          end
          2'b11: data_out = ram_rdata;
          default: ;
        endcase
      end
    end
  end

  word_ram word_ram_inst (
    .clk         (clk),
    .rst_n       (rst_n),
    .ram_en      (ram_en),
    .ram_index   (ram_index),
    .ram_byte_en (ram_byte_en),
    .ram_wdata   (ram_wdata),
    .ram_rdata   (ram_rdata),
    .ram_ready   (ram_ready)
  );

  io_regs io_regs_inst (
    .clk           (clk),
    .rst_n         (rst_n),
    .io_sel_led    (io_sel_led),
    .io_sel_out    (io_sel_out),
    .io_sel_in     (io_sel_in),
    .io_wr         (io_wr),
    .io_rd         (io_rd),
    .io_wdata      (data_in),
    .led           (led),
    .io_rdata      (io_rdata),
    .tx_go         (tx_go),
    .tx_data       (tx_data),
    .tx_busy       (tx_busy),
    .rx_go         (rx_go),
    .rx_data       (rx_data),
    .rx_data_ready (rx_data_ready)
  );

  uart_tx uart_tx_inst (
    .clk   (clk),
    .rst_n (rst_n),
    .go    (tx_go),
    .data  (tx_data),
    .tx    (uart_tx),
    .busy  (tx_busy)
  );

  uart_rx uart_rx_inst (
    .clk        (clk),
    .rst_n      (rst_n),
    .rx         (uart_rx),
    .go         (rx_go),
    .data       (rx_data),
    .data_ready (rx_data_ready)
  );

endmodule

`default_nettype wire

// File: verification/ramio_tb.sv
// ======================================================================
// ramio testbench
// replays accesses from a stimulus file, loops the UART back on itself
// and compares read data and LED state with the expected values
// ======================================================================
`timescale 1ns/1ps
`default_nettype none

module ramio_tb;

  logic                   clk;
  logic                   rst_n;
  logic                   enable;
  ramio_pkg::read_type_t  read_type;
  ramio_pkg::write_type_t write_type;
  ramio_pkg::addr_t       address;
  ramio_pkg::word_t       data_in;
  ramio_pkg::word_t       data_out;
  logic                   data_out_ready;
  logic [3:0]             led;
  // tx looped straight back into rx
  wire                    serial_line;

  // one entry per stimulus line
  logic [7:0]             stim_op[$];
  logic [3:0]             stim_type[$];
  ramio_pkg::addr_t       stim_addr[$];
  ramio_pkg::word_t       stim_data[$];
  ramio_pkg::word_t       stim_exp[$];

  int                     checks = 0;
  int                     errors = 0;
  int                     cycle_count = 0;
  int                     cycle_limit = 0;

  ramio ramio_inst (
    .clk            (clk),
    .rst_n          (rst_n),
    .enable         (enable),
    .read_type      (read_type),
    .write_type     (write_type),
    .address        (address),
    .data_in        (data_in),
    .data_out       (data_out),
    .data_out_ready (data_out_ready),
    .led            (led),
    .uart_tx        (serial_line),
    .uart_rx        (serial_line)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // run limit is armed once the stimulus is loaded
  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
      $display("timeout: no result after %0d cycles", cycle_limit);
      $display("checks: %0d, errors: %0d", checks, errors);
      $display("tests failed");
      $finish;
    end
  end

  task automatic load_stimulus();
    int               fd;
    int               n;
    string            line;
    logic [7:0]       op;
    logic [3:0]       typ;
    ramio_pkg::addr_t a;
    ramio_pkg::word_t d;
    ramio_pkg::word_t e;
    fd = $fopen("verification/ramio_stimulus.txt", "r");
    if (fd == 0) begin
      errors++;
      $display("could not open the stimulus file verification/ramio_stimulus.txt");
    end else begin
      while (!$feof(fd)) begin
        if ($fgets(line, fd) == 0) break;
        // skip blank lines and comments
        if (line.len() < 2 || line.getc(0) == "#") continue;
        n = $sscanf(line, "%c %h %h %h %h", op, typ, a, d, e);
        if (n != 5) begin
          errors++;
          $display("stimulus line could not be parsed: %s", line);
        end else begin
          stim_op.push_back(op);
          stim_type.push_back(typ);
          stim_addr.push_back(a);
          stim_data.push_back(d);
          stim_exp.push_back(e);
        end
      end
      $fclose(fd);
    end
  endtask

  task automatic check_value(input ramio_pkg::addr_t addr, input ramio_pkg::word_t exp,
                             input ramio_pkg::word_t got);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("MISMATCH at %0t: address %h expected %h got %h", $time, addr, exp, got);
    end
  endtask

  // write held for one cycle so it does not repeat
  task automatic write_word(input ramio_pkg::addr_t addr, input ramio_pkg::write_type_t wtype,
                            input ramio_pkg::word_t data);
    @(negedge clk);
    enable     = 1'b1;
    write_type = wtype;
    read_type  = '0;
    address    = addr;
    data_in    = data;
    @(negedge clk);
    enable     = 1'b0;
    write_type = '0;
  endtask

  // hold the read until data_out_ready and sample between edges
  // I/O answers in the request cycle, RAM one cycle later
  task automatic read_word(input ramio_pkg::addr_t addr, input ramio_pkg::read_type_t rtype,
                           output ramio_pkg::word_t got);
    int waited;
    int exp_wait;
    waited   = 0;
    exp_wait = 1;
    if (addr == ramio_pkg::ADDR_LED || addr == ramio_pkg::ADDR_UART_OUT ||
        addr == ramio_pkg::ADDR_UART_IN) begin
      exp_wait = 0;
    end
    @(negedge clk);
    enable     = 1'b1;
    read_type  = rtype;
    write_type = '0;
    address    = addr;
    data_in    = '0;
    #1;
    while (!data_out_ready) begin
      @(negedge clk);
      #1;
      waited++;
    end
    checks++;
    assert (waited == exp_wait) else begin
      errors++;
      $display("MISMATCH at %0t: address %h ready after %0d cycles, expected %0d",
               $time, addr, waited, exp_wait);
    end
    got = data_out;
    @(negedge clk);
    enable    = 1'b0;
    read_type = '0;
  endtask

  task automatic check_led(input logic [3:0] exp);
    @(negedge clk);
    #1;
    check_value(ramio_pkg::ADDR_LED, {28'h0, exp}, {28'h0, led});
  endtask

  // send one byte and watch it arrive in the receive mailbox
  task automatic uart_loopback(input ramio_pkg::word_t data, input ramio_pkg::word_t exp);
    ramio_pkg::word_t got;
    // transmitter must be idle first or the byte is lost
    do begin
      read_word(ramio_pkg::ADDR_UART_OUT, 3'b011, got);
    end while (got !== ramio_pkg::MAILBOX_EMPTY);
    write_word(ramio_pkg::ADDR_UART_OUT, 2'b11, data);
    do begin
      read_word(ramio_pkg::ADDR_UART_IN, 3'b011, got);
    end while (got === ramio_pkg::MAILBOX_EMPTY);
    check_value(ramio_pkg::ADDR_UART_IN, exp, got);
    // the read above emptied the mailbox
    read_word(ramio_pkg::ADDR_UART_IN, 3'b011, got);
    check_value(ramio_pkg::ADDR_UART_IN, ramio_pkg::MAILBOX_EMPTY, got);
    // transmit mailbox clears shortly after the stop bit
    do begin
      read_word(ramio_pkg::ADDR_UART_OUT, 3'b011, got);
    end while (got !== ramio_pkg::MAILBOX_EMPTY);
  endtask

  initial begin
    ramio_pkg::word_t got;
    rst_n      = 1'b0;
    enable     = 1'b0;
    read_type  = '0;
    write_type = '0;
    address    = '0;
    data_in    = '0;
    load_stimulus();
    cycle_limit = 200 * stim_op.size();
    repeat (4) @(negedge clk);
    rst_n = 1'b1;
    for (int i = 0; i < stim_op.size(); i++) begin
      case (stim_op[i])
        "W": write_word(stim_addr[i], stim_type[i][1:0], stim_data[i]);
        "R": begin
          read_word(stim_addr[i], stim_type[i][2:0], got);
          check_value(stim_addr[i], stim_exp[i], got);
        end
        "T": uart_loopback(stim_data[i], stim_exp[i]);
        "N": check_led(stim_exp[i][3:0]);
        default: begin
          errors++;
          $display("unknown operation %c in stimulus entry %0d", stim_op[i], i);
        end
      endcase
    end
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: verification/ramio_stimulus.txt
# op type address data expected, all values hex
# op: W write, R read and compare, T uart loopback of data, N check led nibble
N 0 00000000 00000000 0000000f
R 3 fffffff4 00000000 ffffffff
R 3 fffffff8 00000000 ffffffff
W 3 00000000 12345678 00000000
W 3 00000004 deadbeef 00000000
W 3 000003fc a5a5c3c3 00000000
R 3 00000000 00000000 12345678
R 3 00000004 00000000 deadbeef
R 3 000003fc 00000000 a5a5c3c3
R 3 00000404 00000000 deadbeef
R 3 000007fc 00000000 a5a5c3c3
W 3 00000010 00000000 00000000
W 1 00000011 000000ab 00000000
W 2 00000012 0000cdef 00000000
R 3 00000010 00000000 cdefab00
W 1 00000010 00000080 00000000
R 1 00000010 00000000 00000080
R 5 00000010 00000000 ffffff80
R 1 00000011 00000000 000000ab
R 5 00000011 00000000 ffffffab
R 2 00000012 00000000 0000cdef
R 6 00000012 00000000 ffffcdef
R 6 00000010 00000000 ffffab80
R 2 00000011 00000000 00000000
W 2 00000013 00001111 00000000
R 3 00000010 00000000 cdefab80
W 3 fffffffc 00000005 00000000
N 0 00000000 00000000 00000005
R 3 fffffffc 00000000 00000005
W 3 fffffffc 0000003a 00000000
N 0 00000000 00000000 0000000a
R 7 fffffffc 00000000 0000000a
T 3 fffffff8 00000000 00000000
T 3 fffffff8 0000005a 0000005a
T 3 fffffff8 000000ff 000000ff

// File: project.f
hw/ramio_pkg.sv
hw/word_ram.sv
hw/io_regs.sv
hw/uart_tx.sv
hw/uart_rx.sv
hw/ramio.sv
verification/ramio_tb.sv

// File: Makefile
sim:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		-f project.f --top-module ramio_tb -Mdir obj_dir
	@out="$$(./obj_dir/Vramio_tb)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "all tests passed"

clean:
	rm -rf obj_dir

.PHONY: sim clean
